// File: Bender.yml
package:
  name: cpu_backend

sources:
  - common/cpu_pkg.sv
  - mem/mem_stage.sv
  - mem/llbit_reg.sv
  - mem/data_ram.sv
  - source/bus_arbiter.sv
  - source/mem_wb.sv
  - source/regfile.sv
  - source/pipe_ctrl.sv
  - source/cpu_backend.sv
  - target: simulation
    files:
      - dv/clk_gen.sv
      - dv/cpu_backend_sva.sv
      - dv/tb_cpu_backend.sv

// File: common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_addr_t;
  typedef logic [31:0] inst_t;       // Carried for the commit port only.
  typedef logic [4:0]  reg_addr_t;

  // Bit 0 execute, bit 1 EX/MEM, bit 2 MEM/WB, bit 3 writeback.
  typedef logic [3:0]  stall_t;

  typedef enum logic [2:0] {
    MEM_NONE = 3'd0,
    MEM_LW   = 3'd1,
    MEM_SW   = 3'd2,
    MEM_LL   = 3'd3,
    MEM_SC   = 3'd4
  } mem_op_t;

endpackage

`default_nettype wire

// File: dv/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int PERIOD     = 20,
  parameter int RST_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release lands just after an edge, with the other inputs.
  initial
  begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// File: dv/cpu_backend_sva.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_backend_sva (
  input logic clk,
  input logic rst_n,
  input logic flush,
  input logic commit_valid,
  input logic mem_req,
  input logic stallreq,
  input logic ex_hold,
  input logic host_req,
  input logic host_gnt
);

  int unsigned fail_count = 0;

  a_flush_clears_commit: assert property (@(posedge clk) disable iff (!rst_n)
    flush |=> !commit_valid)
  else
  begin
    fail_count++;
    $error("commit_valid high in the cycle after a flush");
  end

  // Hold is up exactly while the host takes a cycle the memory stage wants.
  a_hold_follows_stallreq: assert property (@(posedge clk) disable iff (!rst_n)
    ex_hold == (mem_req && host_req && !flush))
  else
  begin
    fail_count++;
    $error("ex_hold does not follow a lost memory cycle");
  end

  // A lost memory cycle must not show up on the commit port.
  a_no_commit_on_bubble: assert property (@(posedge clk) disable iff (!rst_n)
    stallreq |=> !commit_valid)
  else
  begin
    fail_count++;
    $error("commit_valid high after a stalled memory cycle");
  end

  a_gnt_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    host_gnt |-> host_req)
  else
  begin
    fail_count++;
    $error("host_gnt high without host_req");
  end

endmodule

// Watches the MEM/WB register and the pipeline control.
bind cpu_backend cpu_backend_sva u_sva (
  .clk, .rst_n, .flush, .commit_valid, .mem_req, .stallreq, .ex_hold,
  .host_req, .host_gnt
);

`default_nettype wire

// File: dv/tb_cpu_backend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_backend;

  import cpu_pkg::*;

  localparam int unsigned RAM_WORDS  = 64;
  localparam int          NUM_TESTS  = 5;
  localparam int          RST_CYCLES = 10;

  logic       clk;
  logic       rst_n;
  logic       ex_valid;
  inst_addr_t ex_pc;
  inst_t      ex_inst;
  reg_addr_t  ex_wd;
  logic       ex_wreg;
  word_t      ex_wdata;
  mem_op_t    ex_mem_op;
  word_t      ex_mem_data;
  logic       flush;
  logic       ex_hold;
  logic       host_req;
  logic       host_we;
  word_t      host_addr;
  word_t      host_wdata;
  logic       host_gnt;
  word_t      host_rdata;
  logic       commit_valid;
  inst_addr_t commit_pc;
  inst_t      commit_inst;
  reg_addr_t  rf_raddr;
  word_t      rf_rdata;

  // Reference model and its rollback copy.
  word_t m_regs [32];
  word_t m_mem [RAM_WORDS];
  logic  m_llbit;
  word_t s_regs [32];
  word_t s_mem [RAM_WORDS];
  logic  s_llbit;

  inst_addr_t q_pc [$];      // Expected commits in program order.
  inst_t      q_inst [$];
  logic       q_wreg [$];
  reg_addr_t  q_wd [$];
  word_t      q_val [$];

  string      test_name;
  integer     seed;
  integer     host_seed;
  inst_addr_t next_pc;
  logic       rf_check_pending;

  clk_gen #(.PERIOD(20), .RST_CYCLES(RST_CYCLES)) u_clk_gen (.clk, .rst_n);

  cpu_backend #(.RAM_WORDS(RAM_WORDS)) u_dut (.*);

  task automatic end_with_failure(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string what, input word_t expected, input word_t actual);
    if (expected !== actual)
    begin
      end_with_failure($sformatf("ERR %s %s: expected %08h, actual %08h",
                                 test_name, what, expected, actual));
    end
  endtask

  // Expected register write; also steps the model in program order.
  function automatic word_t predict(input mem_op_t op, input reg_addr_t wd, input logic wreg,
                                    input word_t alu, input word_t sdata);
    word_t       result;
    int unsigned idx;
    idx = alu % RAM_WORDS;
    case (op)
      MEM_LW: result = m_mem[idx];
      MEM_LL:
      begin
        result  = m_mem[idx];
        m_llbit = 1'b1;
      end
      MEM_SW:
      begin
        m_mem[idx] = sdata;
        result     = alu;
      end
      MEM_SC:
      begin
        result = {31'd0, m_llbit};
        if (m_llbit)
          m_mem[idx] = sdata;
        m_llbit = 1'b0;        // Cleared whether or not it stores.
      end
      default: result = alu;
    endcase
    if (wreg && wd != 5'd0)
      m_regs[wd] = result;
    return (wd == 5'd0) ? '0 : result;
  endfunction

  task automatic save_model;
    s_regs  = m_regs;
    s_mem   = m_mem;
    s_llbit = m_llbit;
  endtask

  task automatic restore_model;
    m_regs  = s_regs;
    m_mem   = s_mem;
    m_llbit = s_llbit;
  endtask

  task automatic drop_last(input int n);
    repeat (n)
    begin
      void'(q_pc.pop_back());
      void'(q_inst.pop_back());
      void'(q_wreg.pop_back());
      void'(q_wd.pop_back());
      void'(q_val.pop_back());
    end
  endtask

  task automatic drive_inst(input mem_op_t op, input reg_addr_t wd, input logic wreg,
                            input word_t alu, input word_t sdata);
    inst_t inst;
    inst        = $random(seed);
    ex_valid    = 1'b1;
    ex_pc       = next_pc;
    ex_inst     = inst;
    ex_wd       = wd;
    ex_wreg     = wreg;
    ex_wdata    = alu;
    ex_mem_op   = op;
    ex_mem_data = sdata;
    q_pc.push_back(next_pc);
    q_inst.push_back(inst);
    q_wreg.push_back(wreg);
    q_wd.push_back(wd);
    q_val.push_back(predict(op, wd, wreg, alu, sdata));
    next_pc += 4;
  endtask

  // Keeps the inputs steady for as long as ex_hold is seen before the edge.
  task automatic wait_accept;
    logic held;
    do
    begin
      @(negedge clk);
      held = ex_hold;
      @(posedge clk);
      #2;
    end
    while (held);
    ex_valid = 1'b0;
  endtask

  task automatic issue(input mem_op_t op, input reg_addr_t wd, input logic wreg,
                       input word_t alu, input word_t sdata);
    drive_inst(op, wd, wreg, alu, sdata);
    wait_accept();
  endtask

  task automatic host_access(input logic we, input int unsigned addr, input word_t wdata,
                             output word_t rdata, output logic held);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    @(negedge clk);
    check("host_gnt", 32'd1, {31'd0, host_gnt});
    rdata = host_rdata;
    held  = ex_hold;
    @(posedge clk);
    #2;
    host_req = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic host_read_check(input int unsigned addr);
    word_t rd;
    logic  held;
    host_access(1'b0, addr, '0, rd, held);
    check($sformatf("host read [%0d]", addr), m_mem[addr], rd);
  endtask

  task automatic drain;
    while (q_pc.size() != 0 || rf_check_pending)
    begin
      @(posedge clk);
      #2;
    end
    repeat (3) @(posedge clk);   // Room for a stray commit to show up.
    #2;
  endtask

  task automatic alu_test;
    test_name = "alu";
    issue(MEM_NONE, 5'd1, 1'b1, 32'h1111_1111, '0);
    issue(MEM_NONE, 5'd2, 1'b1, 32'h2222_2222, '0);
    issue(MEM_NONE, 5'd0, 1'b1, 32'hdead_beef, '0);
    issue(MEM_NONE, 5'd31, 1'b1, 32'h8000_0001, '0);
    issue(MEM_NONE, 5'd1, 1'b1, 32'h0bad_f00d, '0);
    drain();
  endtask

  task automatic store_load_test;
    test_name = "store_load";
    issue(MEM_SW, 5'd0, 1'b0, 32'd5, 32'hcafe_f00d);
    issue(MEM_LW, 5'd3, 1'b1, 32'd5, '0);
    issue(MEM_SW, 5'd0, 1'b0, 32'd63, 32'h0123_4567);
    issue(MEM_LW, 5'd4, 1'b1, 32'd63, '0);
    drain();
    host_read_check(5);
    host_read_check(63);
  endtask

  task automatic llsc_test;
    test_name = "ll_sc";
    issue(MEM_SW, 5'd0, 1'b0, 32'd9, 32'ha5a5_a5a5);
    issue(MEM_LL, 5'd4, 1'b1, 32'd9, '0);
    issue(MEM_SC, 5'd5, 1'b1, 32'd9, 32'h1234_abcd);
    issue(MEM_SC, 5'd6, 1'b1, 32'd9, 32'h5555_5555);   // Link is gone.
    issue(MEM_LW, 5'd7, 1'b1, 32'd9, '0);
    drain();
    host_read_check(9);
  endtask

  task automatic flush_test;
    test_name = "flush";
    issue(MEM_SW, 5'd0, 1'b0, 32'd12, 32'habcd_ef01);
    issue(MEM_LL, 5'd5, 1'b1, 32'd12, '0);
    save_model();
    issue(MEM_NONE, 5'd6, 1'b1, 32'h0000_0111, '0);   // In EX/MEM at the flush.
    flush = 1'b1;
    drive_inst(MEM_NONE, 5'd7, 1'b1, 32'h0000_0222, '0);
    @(posedge clk);
    #2;
    flush    = 1'b0;
    ex_valid = 1'b0;
    restore_model();
    drop_last(2);
    m_llbit = 1'b0;
    issue(MEM_SC, 5'd8, 1'b1, 32'd12, 32'h0000_0077);
    drain();
    host_read_check(12);
  endtask

  task automatic host_traffic;
    int unsigned addr;
    word_t       wdata;
    word_t       rd;
    logic        held;
    repeat (24)
    begin
      repeat ({$random(host_seed)} % 3)
      begin
        @(posedge clk);
        #2;
      end
      addr  = 32 + {$random(host_seed)} % 32;   // Upper half belongs to the host.
      wdata = $random(host_seed);
      if ($random(host_seed) & 1)
      begin
        host_access(1'b1, addr, wdata, rd, held);
        m_mem[addr] = wdata;
      end
      else
      begin
        host_access(1'b0, addr, '0, rd, held);
        check("host read", m_mem[addr], rd);
      end
    end
  endtask

  task automatic random_test;
    mem_op_t   op;
    reg_addr_t wd;
    word_t     alu;
    word_t     rd;
    logic      held;
    test_name = "random";
    issue(MEM_LW, 5'd10, 1'b1, 32'd3, '0);
    host_access(1'b0, 40, '0, rd, held);   // The load sits in EX/MEM here.
    check("ex_hold while host wins", 32'd1, {31'd0, held});
    check("host read", m_mem[40], rd);
    host_seed = seed ^ 32'h5a5a;
    fork
      begin
        repeat (48)
        begin
          op  = mem_op_t'({$random(seed)} % 5);
          wd  = {$random(seed)} % 32;
          alu = (op == MEM_NONE) ? word_t'($random(seed)) : word_t'({$random(seed)} % 8);
          issue(op, wd, op != MEM_SW, alu, $random(seed));
          if ({$random(seed)} % 4 == 0)
          begin
            @(posedge clk);
            #2;
          end
        end
      end
      host_traffic();
    join
    drain();
    for (int a = 0; a < 8; a++)
    begin
      host_read_check(a);
    end
  endtask

  // Takes each commit in order; the register value is read one edge later.
  initial
  begin : compare_commits
    reg_addr_t pend_wd;
    word_t     pend_val;
    pend_wd          = '0;
    pend_val         = '0;
    rf_raddr         = '0;
    rf_check_pending = 1'b0;
    forever
    begin
      @(posedge clk);
      #1;
      if (rf_check_pending)
      begin
        check($sformatf("rf_rdata r%0d", pend_wd), pend_val, rf_rdata);
        rf_check_pending = 1'b0;
      end
      if (rst_n && commit_valid)
      begin
        if (q_pc.size() == 0)
        begin
          end_with_failure("A commit arrived with no instruction outstanding.");
        end
        else
        begin
          check("commit_pc", q_pc.pop_front(), commit_pc);
          check("commit_inst", q_inst.pop_front(), commit_inst);
          pend_wd          = q_wd.pop_front();
          pend_val         = q_val.pop_front();
          rf_check_pending = q_wreg.pop_front();
        end
      end
      #1;
      rf_raddr = pend_wd;
    end
  end

  initial
  begin
    wait (u_dut.u_sva.fail_count != 0);
    end_with_failure("A bound assertion failed.");
  end

  initial
  begin
    repeat (NUM_TESTS * 200 + RST_CYCLES) @(posedge clk);
    end_with_failure("Watchdog timeout: the tests did not finish in time.");
  end

  initial
  begin
    seed        = 32'hb36c;
    host_seed   = 0;
    next_pc     = 32'h0000_1000;
    test_name   = "reset";
    ex_valid    = 1'b0;
    ex_pc       = '0;
    ex_inst     = '0;
    ex_wd       = '0;
    ex_wreg     = 1'b0;
    ex_wdata    = '0;
    ex_mem_op   = MEM_NONE;
    ex_mem_data = '0;
    flush       = 1'b0;
    host_req    = 1'b0;
    host_we     = 1'b0;
    host_addr   = '0;
    host_wdata  = '0;
    foreach (m_regs[i]) m_regs[i] = '0;
    foreach (m_mem[i]) m_mem[i] = '0;
    m_llbit = 1'b0;
    @(posedge rst_n);
    @(posedge clk);
    #2;
    alu_test();
    store_load_test();
    llsc_test();
    flush_test();
    random_test();
    if (u_dut.u_sva.fail_count == 0)
    begin
      $display("Done: no errors");
      $finish;
    end
    else
    begin
      end_with_failure("Assertion failures were reported during the run.");
    end
  end

endmodule

`default_nettype wire

// File: mem/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter  int unsigned RAM_WORDS = 64,
  localparam int unsigned AW        = $clog2(RAM_WORDS)
) (
  input  logic           clk,
  input  logic           we,
  input  logic [AW-1:0]  addr,
  input  cpu_pkg::word_t wdata,
  output cpu_pkg::word_t rdata
);

  import cpu_pkg::*;

  word_t mem [RAM_WORDS];

  // Contents start out as zero.
  initial
  begin
    for (int i = 0; i < RAM_WORDS; i++)
    begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[addr] <= wdata;
    end
  end

  assign rdata = mem[addr];   // Asynchronous read.

endmodule

`default_nettype wire

// File: mem/llbit_reg.sv
`timescale 1ns/1ps
`default_nettype none

module llbit_reg (
  input  logic clk,
  input  logic rst_n,
  input  logic flush,
  input  logic we,
  input  logic value,
  output logic llbit
);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      llbit <= 1'b0;
    end
    else if (flush)
    begin
      llbit <= 1'b0;    // Flush beats a same-cycle write.
    end
    else if (we)
    begin
      llbit <= value;
    end
  end

endmodule

`default_nettype wire

// File: mem/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  cpu_pkg::stall_t     stall,
  input  logic                flush,
  input  logic                ex_valid,
  input  cpu_pkg::inst_addr_t ex_pc,
  input  cpu_pkg::inst_t      ex_inst,
  input  cpu_pkg::reg_addr_t  ex_wd,
  input  logic                ex_wreg,
  input  cpu_pkg::word_t      ex_wdata,
  input  cpu_pkg::mem_op_t    ex_mem_op,
  input  cpu_pkg::word_t      ex_mem_data,
  input  logic                llbit,
  input  logic                wb_llbit_we,
  input  logic                wb_llbit_value,
  output logic                mem_req,
  output logic                mem_we,
  output cpu_pkg::word_t      mem_addr,
  output cpu_pkg::word_t      mem_wdata,
  input  logic                mem_gnt,
  input  cpu_pkg::word_t      mem_rdata,
  output logic                stallreq,
  output logic                mem_valid,
  output cpu_pkg::inst_addr_t mem_pc,
  output cpu_pkg::inst_t      mem_inst,
  output cpu_pkg::reg_addr_t  mem_wd,
  output logic                mem_wreg,
  output cpu_pkg::word_t      mem_result,
  output logic                mem_llbit_we,
  output logic                mem_llbit_value
);

  import cpu_pkg::*;

  logic       valid_q;
  logic       wreg_q;
  mem_op_t    op_q;
  inst_addr_t pc_q;
  inst_t      inst_q;
  reg_addr_t  wd_q;
  word_t      wdata_q;
  word_t      mdata_q;
  logic       llbit_cur;
  logic       sc_ok;
  logic       served;

  // EX/MEM control fields.
  always_ff @(posedge clk)
  begin
    if (!rst_n || flush)
    begin
      valid_q <= 1'b0;
      wreg_q  <= 1'b0;
      op_q    <= MEM_NONE;
    end
    else if (stall[0] && !stall[1])
    begin
      valid_q <= 1'b0;          // Bubble.
      wreg_q  <= 1'b0;
      op_q    <= MEM_NONE;
    end
    else if (!stall[1])
    begin
      valid_q <= ex_valid;
      wreg_q  <= ex_wreg;
      op_q    <= ex_mem_op;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall[1])
    begin
      pc_q    <= ex_pc;
      inst_q  <= ex_inst;
      wd_q    <= ex_wd;
      wdata_q <= ex_wdata;
      mdata_q <= ex_mem_data;
    end
  end

  // A link-bit write still sitting in MEM/WB wins over the register.
  assign llbit_cur = wb_llbit_we ? wb_llbit_value : llbit;
  assign sc_ok     = (op_q == MEM_SC) && llbit_cur;

  assign mem_req   = valid_q && (op_q != MEM_NONE);
  assign mem_we    = (op_q == MEM_SW) || sc_ok;
  assign mem_addr  = wdata_q;   // ALU result is the word address.
  assign mem_wdata = mdata_q;
  assign stallreq  = mem_req && !mem_gnt;
  assign served    = !stallreq;

  // A lost memory cycle hands MEM/WB an empty slot.
  assign mem_valid       = valid_q && served;
  assign mem_wreg        = wreg_q && served;
  assign mem_pc          = pc_q;
  assign mem_inst        = inst_q;
  assign mem_wd          = wd_q;
  assign mem_llbit_we    = valid_q && served && (op_q == MEM_LL || op_q == MEM_SC);
  assign mem_llbit_value = (op_q == MEM_LL);   // SC always clears it.

  always_comb
  begin
    case (op_q)
      MEM_LW, MEM_LL: mem_result = mem_rdata;
      MEM_SC:         mem_result = {31'd0, sc_ok};
      default:        mem_result = wdata_q;
    endcase
  end

endmodule

`default_nettype wire

// File: sim.f
common/cpu_pkg.sv
mem/mem_stage.sv
mem/llbit_reg.sv
mem/data_ram.sv
source/bus_arbiter.sv
source/mem_wb.sv
source/regfile.sv
source/pipe_ctrl.sv
source/cpu_backend.sv
dv/clk_gen.sv
dv/cpu_backend_sva.sv
dv/tb_cpu_backend.sv

// File: source/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
  parameter  int unsigned RAM_WORDS = 64,
  localparam int unsigned AW        = $clog2(RAM_WORDS)
) (
  input  logic           host_req,
  input  logic           host_we,
  input  cpu_pkg::word_t host_addr,
  input  cpu_pkg::word_t host_wdata,
  output logic           host_gnt,
  output cpu_pkg::word_t host_rdata,
  input  logic           mem_req,
  input  logic           mem_we,
  input  cpu_pkg::word_t mem_addr,
  input  cpu_pkg::word_t mem_wdata,
  output logic           mem_gnt,
  output cpu_pkg::word_t mem_rdata,
  output logic           ram_we,
  output logic [AW-1:0]  ram_addr,
  output cpu_pkg::word_t ram_wdata,
  input  cpu_pkg::word_t ram_rdata
);

  // Host always wins a shared cycle.
  assign host_gnt = host_req;
  assign mem_gnt  = mem_req && !host_req;

  assign ram_we    = host_gnt ? host_we : (mem_gnt && mem_we);
  assign ram_addr  = host_gnt ? host_addr[AW-1:0] : mem_addr[AW-1:0];
  assign ram_wdata = host_gnt ? host_wdata : mem_wdata;

  assign host_rdata = ram_rdata;
  assign mem_rdata  = ram_rdata;

endmodule

`default_nettype wire

// File: source/cpu_backend.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_backend #(
  parameter int unsigned         RAM_WORDS = 64,
  parameter cpu_pkg::inst_addr_t RST_PC    = '0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ex_valid,
  input  cpu_pkg::inst_addr_t ex_pc,
  input  cpu_pkg::inst_t      ex_inst,
  input  cpu_pkg::reg_addr_t  ex_wd,
  input  logic                ex_wreg,
  input  cpu_pkg::word_t      ex_wdata,
  input  cpu_pkg::mem_op_t    ex_mem_op,
  input  cpu_pkg::word_t      ex_mem_data,
  input  logic                flush,
  output logic                ex_hold,
  input  logic                host_req,
  input  logic                host_we,
  input  cpu_pkg::word_t      host_addr,
  input  cpu_pkg::word_t      host_wdata,
  output logic                host_gnt,
  output cpu_pkg::word_t      host_rdata,
  output logic                commit_valid,
  output cpu_pkg::inst_addr_t commit_pc,
  output cpu_pkg::inst_t      commit_inst,
  input  cpu_pkg::reg_addr_t  rf_raddr,
  output cpu_pkg::word_t      rf_rdata
);

  import cpu_pkg::*;

  localparam int unsigned AW = $clog2(RAM_WORDS);

  stall_t     stall;
  logic       stallreq;
  logic       llbit;
  logic       mem_req, mem_we, mem_gnt;
  word_t      mem_addr, mem_wdata, mem_rdata;
  logic       ram_we;
  logic [AW-1:0] ram_addr;
  word_t      ram_wdata, ram_rdata;
  logic       mem_valid, mem_wreg, mem_llbit_we, mem_llbit_value;
  inst_addr_t mem_pc;
  inst_t      mem_inst;
  reg_addr_t  mem_wd;
  word_t      mem_result;
  reg_addr_t  wb_wd;
  logic       wb_wreg, wb_llbit_we, wb_llbit_value;
  word_t      wb_wdata;

  mem_stage u_mem_stage (
    .clk, .rst_n, .stall, .flush,
    .ex_valid, .ex_pc, .ex_inst, .ex_wd, .ex_wreg, .ex_wdata, .ex_mem_op, .ex_mem_data,
    .llbit, .wb_llbit_we, .wb_llbit_value,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_gnt, .mem_rdata, .stallreq,
    .mem_valid, .mem_pc, .mem_inst, .mem_wd, .mem_wreg, .mem_result,
    .mem_llbit_we, .mem_llbit_value
  );

  llbit_reg u_llbit_reg (
    .clk, .rst_n, .flush, .we(wb_llbit_we), .value(wb_llbit_value), .llbit
  );

  bus_arbiter #(.RAM_WORDS(RAM_WORDS)) u_bus_arbiter (
    .host_req, .host_we, .host_addr, .host_wdata, .host_gnt, .host_rdata,
    .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_gnt, .mem_rdata,
    .ram_we, .ram_addr, .ram_wdata, .ram_rdata
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_data_ram (
    .clk, .we(ram_we), .addr(ram_addr), .wdata(ram_wdata), .rdata(ram_rdata)
  );

  pipe_ctrl u_pipe_ctrl (.stallreq, .flush, .stall, .ex_hold);

  mem_wb #(.RST_PC(RST_PC)) u_mem_wb (
    .clk, .rst_n, .stall, .flush,
    .mem_valid, .mem_pc, .mem_inst, .mem_wd, .mem_wreg, .mem_result,
    .mem_llbit_we, .mem_llbit_value,
    .wb_wd, .wb_wreg, .wb_wdata, .wb_llbit_we, .wb_llbit_value,
    .commit_valid, .commit_pc, .commit_inst
  );

  regfile u_regfile (
    .clk, .rst_n, .we(wb_wreg), .waddr(wb_wd), .wdata(wb_wdata),
    .raddr(rf_raddr), .rdata(rf_rdata)
  );

endmodule

`default_nettype wire

// File: source/mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb #(
  parameter cpu_pkg::inst_addr_t RST_PC = '0
) (
  input  logic                clk,
  input  logic                rst_n,
  input  cpu_pkg::stall_t     stall,
  input  logic                flush,
  input  logic                mem_valid,
  input  cpu_pkg::inst_addr_t mem_pc,
  input  cpu_pkg::inst_t      mem_inst,
  input  cpu_pkg::reg_addr_t  mem_wd,
  input  logic                mem_wreg,
  input  cpu_pkg::word_t      mem_result,
  input  logic                mem_llbit_we,
  input  logic                mem_llbit_value,
  output cpu_pkg::reg_addr_t  wb_wd,
  output logic                wb_wreg,
  output cpu_pkg::word_t      wb_wdata,
  output logic                wb_llbit_we,
  output logic                wb_llbit_value,
  output logic                commit_valid,
  output cpu_pkg::inst_addr_t commit_pc,
  output cpu_pkg::inst_t      commit_inst
);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wb_wd          <= '0;
      wb_wreg        <= 1'b0;
      wb_wdata       <= '0;
      wb_llbit_we    <= 1'b0;
      wb_llbit_value <= 1'b0;
      commit_valid   <= 1'b0;
      commit_pc      <= RST_PC;
      commit_inst    <= '0;
    end
    else if (flush || (stall[2] && !stall[3]))
    begin
      wb_wd          <= '0;     // Flushed or bubble slot.
      wb_wreg        <= 1'b0;
      wb_wdata       <= '0;
      wb_llbit_we    <= 1'b0;
      wb_llbit_value <= 1'b0;
      commit_valid   <= 1'b0;
      commit_pc      <= '0;
      commit_inst    <= '0;
    end
    else if (!stall[2])
    begin
      wb_wd          <= mem_wd;
      wb_wreg        <= mem_wreg;
      wb_wdata       <= mem_result;
      wb_llbit_we    <= mem_llbit_we;
      wb_llbit_value <= mem_llbit_value;
      commit_valid   <= mem_valid;
      commit_pc      <= mem_pc;
      commit_inst    <= mem_inst;
    end
  end

endmodule

`default_nettype wire

// File: source/pipe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
  input  logic            stallreq,
  input  logic            flush,
  output cpu_pkg::stall_t stall,
  output logic            ex_hold
);

  // Memory stall holds execute and EX/MEM; MEM/WB gets a bubble.
  always_comb
  begin
    if (flush)
    begin
      stall = '0;
    end
    else
    begin
      stall = {2'b00, stallreq, stallreq};
    end
  end

  assign ex_hold = stall[0];

endmodule

`default_nettype wire

// File: source/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               we,
  input  cpu_pkg::reg_addr_t waddr,
  input  cpu_pkg::word_t     wdata,
  input  cpu_pkg::reg_addr_t raddr,
  output cpu_pkg::word_t     rdata
);

  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (we && waddr != 5'd0)
    begin
      regs[waddr] <= wdata;   // r0 stays zero.
    end
  end

  // No write-through; a same-cycle write shows up next cycle.
  assign rdata = regs[raddr];

endmodule

`default_nettype wire
